//--- sim.f
design/core_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/commit_stage.sv
design/mini_core.sv
test/tb_clock.sv
test/tb_mini_core.sv

//--- run.sh
#!/bin/sh
# compile the mini_core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mini_core -f sim.f

# a failed check ends in $fatal, which gives a non-zero exit status
./obj_dir/Vtb_mini_core

//--- test/tb_mini_core.sv
// testbench for the four-stage core
// LFSR-generated program memory, sequential reference model,
// compare tasks and a cycle timeout

`timescale 1ns/1ps

module tb_mini_core;
  import core_pkg::*;

  // non-zero so that the boot address has to reach the PC register
  localparam word_t BootAddr      = 32'h0000_0100;
  localparam int    NumCommits    = 2000;
  // a retirement never waits more than three cycles
  localparam int    TimeoutCycles = 3 * NumCommits + 20;

  logic     clk;
  logic     rst_n;
  instr_t   instr;
  word_t    fetch_addr;
  logic     commit_valid;
  word_t    commit_pc;
  reg_idx_t commit_rd;
  logic     commit_we;
  word_t    commit_wdata;
  logic     commit_illegal;

  instr_t   prog_mem [64];
  instr_t   fill_word;
  word_t    lfsr;
  word_t    model_pc;
  word_t    model_regs [32];
  int       commit_count;
  int       cycle_count = 0;

  tb_clock #(
    .HalfPeriodNs ( 4 ),
    .ResetCycles  ( 4 )
  ) i_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  mini_core #(
    .BootAddr ( BootAddr )
  ) i_dut (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .instr_i          ( instr          ),
    .fetch_addr_o     ( fetch_addr     ),
    .commit_valid_o   ( commit_valid   ),
    .commit_pc_o      ( commit_pc      ),
    .commit_rd_o      ( commit_rd      ),
    .commit_we_o      ( commit_we      ),
    .commit_wdata_o   ( commit_wdata   ),
    .commit_illegal_o ( commit_illegal )
  );

  // --------------------------------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s is x%0d, expected x%0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
                               $time, name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // random program
  // --------------------------------------------------------------------------
  // taps for x^32 + x^22 + x^2 + x + 1
  function automatic word_t lfsr_step(input word_t s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // roughly 60 % reg-reg, 25 % immediate, 10 % branch, 5 % unsupported
  task automatic make_instr(output instr_t w);
    word_t      sel;
    word_t      op;
    word_t      rd;
    word_t      rs1;
    word_t      rs2;
    word_t      imm;
    logic [2:0] f3;
    logic [6:0] f7;
    draw_bits(10, sel);
    // x0 to x3 only to keep dependencies dense
    draw_bits(2, rd);
    draw_bits(2, rs1);
    draw_bits(2, rs2);
    f7 = 7'b0000000;
    if (sel < 32'd614) begin
      draw_bits(3, op);
      case (op[2:0])
        3'd0:       f3 = 3'b000;
        3'd1, 3'd7: begin
          f3 = 3'b000;
          f7 = 7'b0100000;
        end
        3'd2:       f3 = 3'b111;
        3'd3:       f3 = 3'b110;
        3'd4:       f3 = 3'b100;
        default:    f3 = 3'b010;
      endcase
      w = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    end else if (sel < 32'd870) begin
      draw_bits(2, op);
      draw_bits(12, imm);
      case (op[1:0])
        2'd0:    f3 = 3'b000;
        2'd1:    f3 = 3'b100;
        2'd2:    f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      w = {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    end else if (sel < 32'd973) begin
      draw_bits(1, op);
      draw_bits(3, imm);
      // forward by 1 to 8 words
      imm = (imm + 32'd1) << 2;
      f3  = {2'b00, op[0]};
      w   = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    end else begin
      draw_bits(32, w);
      if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b1100011) begin
        w[2] = ~w[2];
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model stepping one instruction per retirement
  // --------------------------------------------------------------------------
  task automatic retire_and_check();
    instr_t   w;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    imm_i;
    word_t    imm_b;
    word_t    result;
    word_t    next_pc;
    logic     legal;
    logic     writes;
    w       = prog_mem[model_pc[7:2]];
    rd      = w[11:7];
    a       = model_regs[w[19:15]];
    b       = model_regs[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    legal   = 1'b1;
    writes  = 1'b0;
    result  = '0;
    next_pc = model_pc + 32'd4;
    case (w[6:0])
      7'b0110011: begin
        writes = 1'b1;
        case ({w[31:25], w[14:12]})
          {7'h00, 3'b000}: result = a + b;
          {7'h20, 3'b000}: result = a - b;
          {7'h00, 3'b111}: result = a & b;
          {7'h00, 3'b110}: result = a | b;
          {7'h00, 3'b100}: result = a ^ b;
          {7'h00, 3'b010}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:         legal = 1'b0;
        endcase
      end
      7'b0010011: begin
        writes = 1'b1;
        case (w[14:12])
          3'b000:  result = a + imm_i;
          3'b111:  result = a & imm_i;
          3'b110:  result = a | imm_i;
          3'b100:  result = a ^ imm_i;
          default: legal = 1'b0;
        endcase
      end
      7'b1100011: begin
        case (w[14:12])
          3'b000: if (a == b) next_pc = model_pc + imm_b;
          3'b001: if (a != b) next_pc = model_pc + imm_b;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    writes = writes & legal & (rd != 5'd0);

    check_word("commit_pc_o", commit_pc, model_pc);
    check_flag("commit_illegal_o", commit_illegal, ~legal);
    check_flag("commit_we_o", commit_we, writes);
    if (writes) begin
      check_reg("commit_rd_o", commit_rd, rd);
      check_word("commit_wdata_o", commit_wdata, result);
      model_regs[rd] = result;
    end
    model_pc = next_pc;
  endtask

  // --------------------------------------------------------------------------
  // instruction memory refreshed a little after each edge
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    #1;
    instr = prog_mem[fetch_addr[7:2]];
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      report_failure($sformatf("timeout: only %0d of %0d instructions retired in %0d cycles",
                               commit_count, NumCommits, TimeoutCycles));
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    instr        = '0;
    lfsr         = 32'h2a530e1d;
    commit_count = 0;
    model_pc     = BootAddr;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      make_instr(fill_word);
      prog_mem[i] = fill_word;
    end

    wait (rst_n == 1'b1);
    // state right after reset
    check_word("fetch_addr_o", fetch_addr, BootAddr);
    check_flag("commit_valid_o", commit_valid, 1'b0);

    // registered commit outputs are sampled away from the rising edge
    while (commit_count < NumCommits) begin
      @(negedge clk);
      if (commit_valid) begin
        retire_and_check();
        commit_count++;
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- test/tb_clock.sv
// clock and reset generator for the testbench
// 8 ns period, active-low reset held for a number of cycles

`timescale 1ns/1ps

module tb_clock #(
  parameter int HalfPeriodNs = 4,
  parameter int ResetCycles  = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // release shortly after an edge so the first active edge is clean
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- design/mini_core.sv
// top level of the four-stage in-order core
// fetch, decode, execute and commit with write-back and forwarding

`timescale 1ns/1ps

module mini_core #(
  parameter core_pkg::word_t BootAddr = 32'h0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::instr_t    instr_i,
  output core_pkg::word_t     fetch_addr_o,
  output logic                commit_valid_o,
  output core_pkg::word_t     commit_pc_o,
  output core_pkg::reg_idx_t  commit_rd_o,
  output logic                commit_we_o,
  output core_pkg::word_t     commit_wdata_o,
  output logic                commit_illegal_o
);
  import core_pkg::*;

  // fetch to decode
  logic     if_valid;
  word_t    if_pc;
  instr_t   if_instr;

  // decode to execute
  logic     id_valid;
  word_t    id_pc;
  alu_op_e  id_alu_op;
  word_t    id_op_a;
  word_t    id_op_b;
  reg_idx_t id_rd;
  logic     id_we;
  logic     id_illegal;
  logic     id_is_branch;
  logic     id_branch_ne;
  word_t    id_branch_target;

  // execute to commit, fetch and decode
  logic     redirect;
  word_t    redirect_pc;
  logic     ex_valid;
  word_t    ex_pc;
  reg_idx_t ex_rd;
  logic     ex_we;
  word_t    ex_result;
  logic     ex_illegal;

  // commit write-back, also the second forwarding source
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  // -------------------------------------------------------------------------
  // fetch
  // -------------------------------------------------------------------------
  fetch_stage #(
    .BootAddr      ( BootAddr     )
  ) i_fetch_stage (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .redirect_i    ( redirect     ),
    .redirect_pc_i ( redirect_pc  ),
    .instr_i       ( instr_i      ),
    .fetch_addr_o  ( fetch_addr_o ),
    .if_valid_o    ( if_valid     ),
    .if_pc_o       ( if_pc        ),
    .if_instr_o    ( if_instr     )
  );

  // -------------------------------------------------------------------------
  // decode
  // -------------------------------------------------------------------------
  decode_stage i_decode_stage (
    .clk_i              ( clk_i            ),
    .rst_ni             ( rst_ni           ),
    .flush_i            ( redirect         ),
    .if_valid_i         ( if_valid         ),
    .if_pc_i            ( if_pc            ),
    .if_instr_i         ( if_instr         ),
    .fwd_ex_we_i        ( ex_we            ),
    .fwd_ex_rd_i        ( ex_rd            ),
    .fwd_ex_data_i      ( ex_result        ),
    .fwd_cm_we_i        ( wr_en            ),
    .fwd_cm_rd_i        ( wr_idx           ),
    .fwd_cm_data_i      ( wr_data          ),
    .wr_en_i            ( wr_en            ),
    .wr_idx_i           ( wr_idx           ),
    .wr_data_i          ( wr_data          ),
    .id_valid_o         ( id_valid         ),
    .id_pc_o            ( id_pc            ),
    .id_alu_op_o        ( id_alu_op        ),
    .id_op_a_o          ( id_op_a          ),
    .id_op_b_o          ( id_op_b          ),
    .id_rd_o            ( id_rd            ),
    .id_we_o            ( id_we            ),
    .id_illegal_o       ( id_illegal       ),
    .id_is_branch_o     ( id_is_branch     ),
    .id_branch_ne_o     ( id_branch_ne     ),
    .id_branch_target_o ( id_branch_target )
  );

  // -------------------------------------------------------------------------
  // execute
  // -------------------------------------------------------------------------
  execute_stage i_execute_stage (
    .id_valid_i         ( id_valid         ),
    .id_pc_i            ( id_pc            ),
    .id_alu_op_i        ( id_alu_op        ),
    .id_op_a_i          ( id_op_a          ),
    .id_op_b_i          ( id_op_b          ),
    .id_rd_i            ( id_rd            ),
    .id_we_i            ( id_we            ),
    .id_illegal_i       ( id_illegal       ),
    .id_is_branch_i     ( id_is_branch     ),
    .id_branch_ne_i     ( id_branch_ne     ),
    .id_branch_target_i ( id_branch_target ),
    .redirect_o         ( redirect         ),
    .redirect_pc_o      ( redirect_pc      ),
    .ex_valid_o         ( ex_valid         ),
    .ex_pc_o            ( ex_pc            ),
    .ex_rd_o            ( ex_rd            ),
    .ex_we_o            ( ex_we            ),
    .ex_result_o        ( ex_result        ),
    .ex_illegal_o       ( ex_illegal       )
  );

  // -------------------------------------------------------------------------
  // commit
  // -------------------------------------------------------------------------
  commit_stage i_commit_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .ex_valid_i       ( ex_valid         ),
    .ex_pc_i          ( ex_pc            ),
    .ex_rd_i          ( ex_rd            ),
    .ex_we_i          ( ex_we            ),
    .ex_result_i      ( ex_result        ),
    .ex_illegal_i     ( ex_illegal       ),
    .wr_en_o          ( wr_en            ),
    .wr_idx_o         ( wr_idx           ),
    .wr_data_o        ( wr_data          ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_we_o      ( commit_we_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

//--- design/commit_stage.sv
// commit stage holding the retirement record
// drives the register-file write port and the commit outputs

`timescale 1ns/1ps

module commit_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ex_valid_i,
  input  core_pkg::word_t     ex_pc_i,
  input  core_pkg::reg_idx_t  ex_rd_i,
  input  logic                ex_we_i,
  input  core_pkg::word_t     ex_result_i,
  input  logic                ex_illegal_i,
  output logic                wr_en_o,
  output core_pkg::reg_idx_t  wr_idx_o,
  output core_pkg::word_t     wr_data_o,
  output logic                commit_valid_o,
  output core_pkg::word_t     commit_pc_o,
  output core_pkg::reg_idx_t  commit_rd_o,
  output logic                commit_we_o,
  output core_pkg::word_t     commit_wdata_o,
  output logic                commit_illegal_o
);
  import core_pkg::*;

  logic     valid_q;
  logic     we_q;
  logic     illegal_q;
  word_t    pc_q;
  reg_idx_t rd_q;
  word_t    result_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      we_q      <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= ex_valid_i;
      we_q      <= ex_we_i;
      illegal_q <= ex_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q     <= ex_pc_i;
    rd_q     <= ex_rd_i;
    result_q <= ex_result_i;
  end

  // write-back takes effect at the next edge
  assign wr_en_o   = valid_q & we_q;
  assign wr_idx_o  = rd_q;
  assign wr_data_o = result_q;

  // retirement record
  assign commit_valid_o   = valid_q;
  assign commit_pc_o      = pc_q;
  assign commit_rd_o      = rd_q;
  assign commit_we_o      = valid_q & we_q;
  assign commit_wdata_o   = result_q;
  assign commit_illegal_o = valid_q & illegal_q;

endmodule

//--- design/execute_stage.sv
// execute stage with ALU and branch resolution
// raises the redirect for taken branches

`timescale 1ns/1ps

module execute_stage (
  input  logic                id_valid_i,
  input  core_pkg::word_t     id_pc_i,
  input  core_pkg::alu_op_e   id_alu_op_i,
  input  core_pkg::word_t     id_op_a_i,
  input  core_pkg::word_t     id_op_b_i,
  input  core_pkg::reg_idx_t  id_rd_i,
  input  logic                id_we_i,
  input  logic                id_illegal_i,
  input  logic                id_is_branch_i,
  input  logic                id_branch_ne_i,
  input  core_pkg::word_t     id_branch_target_i,
  output logic                redirect_o,
  output core_pkg::word_t     redirect_pc_o,
  output logic                ex_valid_o,
  output core_pkg::word_t     ex_pc_o,
  output core_pkg::reg_idx_t  ex_rd_o,
  output logic                ex_we_o,
  output core_pkg::word_t     ex_result_o,
  output logic                ex_illegal_o
);
  import core_pkg::*;

  word_t alu_result;
  logic  operands_eq;
  logic  branch_taken;

  always_comb begin
    case (id_alu_op_i)
      AluAdd:  alu_result = id_op_a_i + id_op_b_i;
      AluSub:  alu_result = id_op_a_i - id_op_b_i;
      AluAnd:  alu_result = id_op_a_i & id_op_b_i;
      AluOr:   alu_result = id_op_a_i | id_op_b_i;
      AluXor:  alu_result = id_op_a_i ^ id_op_b_i;
      AluSlt:  alu_result = {31'b0, $signed(id_op_a_i) < $signed(id_op_b_i)};
      default: alu_result = id_op_b_i;
    endcase
  end

  // -------------------------------------------------------------------------
  // branch resolution
  // -------------------------------------------------------------------------
  assign operands_eq  = (id_op_a_i == id_op_b_i);
  assign branch_taken = id_branch_ne_i ? ~operands_eq : operands_eq;

  // not-taken branches fall through, so there is no prediction to repair
  assign redirect_o    = id_valid_i & id_is_branch_i & branch_taken;
  assign redirect_pc_o = id_branch_target_i;

  // stage values for commit and for forwarding into decode
  assign ex_valid_o   = id_valid_i;
  assign ex_pc_o      = id_pc_i;
  assign ex_rd_o      = id_rd_i;
  assign ex_we_o      = id_valid_i & id_we_i;
  assign ex_result_o  = alu_result;
  assign ex_illegal_o = id_valid_i & id_illegal_i;

endmodule

//--- design/decode_stage.sv
// decode stage with instruction decoder, immediates and branch target
// operand read with forwarding from execute and commit
// decode pipeline register

`timescale 1ns/1ps

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  // from fetch
  input  logic                if_valid_i,
  input  core_pkg::word_t     if_pc_i,
  input  core_pkg::instr_t    if_instr_i,
  // forwarding sources
  input  logic                fwd_ex_we_i,
  input  core_pkg::reg_idx_t  fwd_ex_rd_i,
  input  core_pkg::word_t     fwd_ex_data_i,
  input  logic                fwd_cm_we_i,
  input  core_pkg::reg_idx_t  fwd_cm_rd_i,
  input  core_pkg::word_t     fwd_cm_data_i,
  // write-back from commit
  input  logic                wr_en_i,
  input  core_pkg::reg_idx_t  wr_idx_i,
  input  core_pkg::word_t     wr_data_i,
  // to execute
  output logic                id_valid_o,
  output core_pkg::word_t     id_pc_o,
  output core_pkg::alu_op_e   id_alu_op_o,
  output core_pkg::word_t     id_op_a_o,
  output core_pkg::word_t     id_op_b_o,
  output core_pkg::reg_idx_t  id_rd_o,
  output logic                id_we_o,
  output logic                id_illegal_o,
  output logic                id_is_branch_o,
  output logic                id_branch_ne_o,
  output core_pkg::word_t     id_branch_target_o
);
  import core_pkg::*;

  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm_i;
  word_t    imm_b;
  word_t    rs1_rf;
  word_t    rs2_rf;
  word_t    rs1_val;
  word_t    rs2_val;
  alu_op_e  alu_op;
  logic     dec_we;
  logic     illegal;
  logic     is_branch;
  logic     branch_ne;
  logic     use_imm;

  // -------------------------------------------------------------------------
  // instruction fields
  // -------------------------------------------------------------------------
  assign opcode = if_instr_i[6:0];
  assign rd     = if_instr_i[11:7];
  assign funct3 = if_instr_i[14:12];
  assign rs1    = if_instr_i[19:15];
  assign rs2    = if_instr_i[24:20];
  assign funct7 = if_instr_i[31:25];

  assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
  assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                  if_instr_i[30:25], if_instr_i[11:8], 1'b0};

  // -------------------------------------------------------------------------
  // decoder
  // -------------------------------------------------------------------------
  always_comb begin
    alu_op    = AluPass;
    dec_we    = 1'b0;
    illegal   = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    use_imm   = 1'b0;
    case (opcode)
      OpcodeOp: begin
        dec_we = 1'b1;
        if (funct7 == Funct7Base) begin
          case (funct3)
            Funct3AddSub: alu_op = AluAdd;
            Funct3Slt:    alu_op = AluSlt;
            Funct3Xor:    alu_op = AluXor;
            Funct3Or:     alu_op = AluOr;
            Funct3And:    alu_op = AluAnd;
            default:      illegal = 1'b1;
          endcase
        end else if (funct7 == Funct7Sub && funct3 == Funct3AddSub) begin
          alu_op = AluSub;
        end else begin
          illegal = 1'b1;
        end
      end
      OpcodeOpImm: begin
        dec_we  = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          Funct3AddSub: alu_op = AluAdd;
          Funct3Xor:    alu_op = AluXor;
          Funct3Or:     alu_op = AluOr;
          Funct3And:    alu_op = AluAnd;
          default:      illegal = 1'b1;
        endcase
      end
      OpcodeBranch: begin
        is_branch = 1'b1;
        case (funct3)
          Funct3Beq: branch_ne = 1'b0;
          Funct3Bne: branch_ne = 1'b1;
          default:   illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    // illegal words retire without side effects
    if (illegal) begin
      dec_we    = 1'b0;
      is_branch = 1'b0;
    end
    if (rd == '0) begin
      dec_we = 1'b0;
    end
  end

  // -------------------------------------------------------------------------
  // operand read and forwarding
  // -------------------------------------------------------------------------
  regfile i_regfile (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .rs1_i      ( rs1       ),
    .rs2_i      ( rs2       ),
    .rs1_data_o ( rs1_rf    ),
    .rs2_data_o ( rs2_rf    ),
    .wr_en_i    ( wr_en_i   ),
    .wr_idx_i   ( wr_idx_i  ),
    .wr_data_i  ( wr_data_i )
  );

  // youngest producer is applied last; write enables are never set for x0
  always_comb begin
    rs1_val = rs1_rf;
    rs2_val = rs2_rf;
    if (fwd_cm_we_i && fwd_cm_rd_i == rs1) rs1_val = fwd_cm_data_i;
    if (fwd_cm_we_i && fwd_cm_rd_i == rs2) rs2_val = fwd_cm_data_i;
    if (fwd_ex_we_i && fwd_ex_rd_i == rs1) rs1_val = fwd_ex_data_i;
    if (fwd_ex_we_i && fwd_ex_rd_i == rs2) rs2_val = fwd_ex_data_i;
  end

  // -------------------------------------------------------------------------
  // pipeline register
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_valid_o     <= 1'b0;
      id_we_o        <= 1'b0;
      id_illegal_o   <= 1'b0;
      id_is_branch_o <= 1'b0;
    end else if (flush_i || !if_valid_i) begin
      // bubble
      id_valid_o     <= 1'b0;
      id_we_o        <= 1'b0;
      id_illegal_o   <= 1'b0;
      id_is_branch_o <= 1'b0;
    end else begin
      id_valid_o     <= 1'b1;
      id_we_o        <= dec_we;
      id_illegal_o   <= illegal;
      id_is_branch_o <= is_branch;
    end
  end

  always_ff @(posedge clk_i) begin
    id_pc_o            <= if_pc_i;
    id_alu_op_o        <= alu_op;
    id_op_a_o          <= rs1_val;
    id_op_b_o          <= use_imm ? imm_i : rs2_val;
    id_rd_o            <= rd;
    id_branch_ne_o     <= branch_ne;
    id_branch_target_o <= if_pc_i + imm_b;
  end

endmodule

//--- design/fetch_stage.sv
// fetch stage with the PC register and the instruction request
// fetch pipeline register, cleared on a branch redirect

`timescale 1ns/1ps

module fetch_stage #(
  parameter core_pkg::word_t BootAddr = '0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              redirect_i,
  input  core_pkg::word_t   redirect_pc_i,
  input  core_pkg::instr_t  instr_i,
  output core_pkg::word_t   fetch_addr_o,
  output logic              if_valid_o,
  output core_pkg::word_t   if_pc_o,
  output core_pkg::instr_t  if_instr_o
);
  import core_pkg::*;

  word_t pc_q;
  word_t pc_next;

  // memory answers in the same cycle
  assign fetch_addr_o = pc_q;

  // taken branch from execute wins over sequential fetch
  assign pc_next = redirect_i ? redirect_pc_i : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q       <= BootAddr;
      if_valid_o <= 1'b0;
    end else begin
      pc_q       <= pc_next;
      // the word fetched this cycle is on the wrong path
      if_valid_o <= ~redirect_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if_pc_o    <= pc_q;
    if_instr_o <= redirect_i ? NopInstr : instr_i;
  end

endmodule

//--- design/regfile.sv
// integer register file, 31 registers with x0 hard-wired to zero
// two asynchronous read ports and one write port

`timescale 1ns/1ps

module regfile (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  output core_pkg::word_t    rs1_data_o,
  output core_pkg::word_t    rs2_data_o,
  input  logic               wr_en_i,
  input  core_pkg::reg_idx_t wr_idx_i,
  input  core_pkg::word_t    wr_data_i
);
  import core_pkg::*;

  word_t regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // index 0 has no storage
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- design/core_pkg.sv
// shared types and instruction encodings of the integer subset
// ALU operation enum and the flush filler instruction

package core_pkg;

  // -------------------------------------------------------------------------
  // basic widths
  // -------------------------------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // ALU operations, pass-through forwards operand b
  typedef enum logic [2:0] {
    AluAdd  = 3'd0,
    AluSub  = 3'd1,
    AluAnd  = 3'd2,
    AluOr   = 3'd3,
    AluXor  = 3'd4,
    AluSlt  = 3'd5,
    AluPass = 3'd6
  } alu_op_e;

  // -------------------------------------------------------------------------
  // opcodes
  // -------------------------------------------------------------------------
  localparam opcode_t OpcodeOp     = 7'b0110011;
  localparam opcode_t OpcodeOpImm  = 7'b0010011;
  localparam opcode_t OpcodeBranch = 7'b1100011;

  // funct3 for register and immediate forms
  localparam funct3_t Funct3AddSub = 3'b000;
  localparam funct3_t Funct3Slt    = 3'b010;
  localparam funct3_t Funct3Xor    = 3'b100;
  localparam funct3_t Funct3Or     = 3'b110;
  localparam funct3_t Funct3And    = 3'b111;

  // funct3 for branches
  localparam funct3_t Funct3Beq = 3'b000;
  localparam funct3_t Funct3Bne = 3'b001;

  // funct7 selects ADD or SUB
  localparam funct7_t Funct7Base = 7'b0000000;
  localparam funct7_t Funct7Sub  = 7'b0100000;

  // addi x0, x0, 0
  localparam instr_t NopInstr = 32'h0000_0013;

endpackage
